// ==== coreDecode.sv ====
`timescale 1ns/10ps
`include "coreDp_settings.svh"

module coreDecode (
  input  logic                    Clock,
  input  logic                    arstN,
  input  logic                    ReadyQ103H,
  input  logic                    InstValidQ101H,
  input  logic [`COREDP_XLEN-1:0] InstQ101H,
  input  logic [`COREDP_XLEN-1:0] PcQ101H,
  input  logic [`COREDP_XLEN-1:0] RegRdData1Q101H,
  input  logic [`COREDP_XLEN-1:0] RegRdData2Q101H,
  output logic [`COREDP_RIDX-1:0] RegSrc1Q101H,
  output logic [`COREDP_RIDX-1:0] RegSrc2Q101H,
  output logic                    ValidQ102H,
  output logic [`COREDP_RIDX-1:0] RegSrc1Q102H,
  output logic [`COREDP_RIDX-1:0] RegSrc2Q102H,
  output logic [`COREDP_RIDX-1:0] RegDstQ102H,
  output logic                    RegWrEnQ102H,
  output logic                    SelAluPcQ102H,
  output logic                    SelAluImmQ102H,
  output logic                    LuiQ102H,
  output coreDpPkg::tAluOp        AluOpQ102H,
  output logic                    IsBranchQ102H,
  output coreDpPkg::tBranchOp     BranchOpQ102H,
  output logic [`COREDP_XLEN-1:0] ImmediateQ102H,
  output logic [`COREDP_XLEN-1:0] PcQ102H,
  output logic [`COREDP_XLEN-1:0] PreRegRdData1Q102H,
  output logic [`COREDP_XLEN-1:0] PreRegRdData2Q102H
);

  coreDpPkg::tOpcode       OpcodeQ101H;
  coreDpPkg::tAluOp        AluOpQ101H;
  logic [`COREDP_XLEN-1:0] ImmediateQ101H;
  logic RegWrEnQ101H, SelAluPcQ101H, SelAluImmQ101H, LuiQ101H, IsBranchQ101H;

  // funct3/funct7 to ALU op; SUB only exists on reg-reg
  function automatic coreDpPkg::tAluOp aluOpOf(input logic [2:0] funct3, input logic altBit,
                                               input logic isRegReg);
    case (funct3)
      3'b000:  aluOpOf = (altBit && isRegReg) ? coreDpPkg::SUB : coreDpPkg::ADD;
      3'b001:  aluOpOf = coreDpPkg::SLL;
      3'b010:  aluOpOf = coreDpPkg::SLT;
      3'b011:  aluOpOf = coreDpPkg::SLTU;
      3'b100:  aluOpOf = coreDpPkg::XOR;
      3'b101:  aluOpOf = altBit ? coreDpPkg::SRA : coreDpPkg::SRL; // SRAI too
      3'b110:  aluOpOf = coreDpPkg::OR;
      default: aluOpOf = coreDpPkg::AND;
    endcase
  endfunction

  // ==================================================
  // Q101H field split and control decode
  // ==================================================
  assign OpcodeQ101H  = coreDpPkg::tOpcode'(InstQ101H[6:0]);
  assign RegSrc1Q101H = InstQ101H[19:15]; // rs1 to reg file
  assign RegSrc2Q101H = InstQ101H[24:20]; // rs2 to reg file

  always_comb begin : decodeCtrl
    RegWrEnQ101H   = 1'b0;
    SelAluPcQ101H  = 1'b0;
    SelAluImmQ101H = 1'b0;
    LuiQ101H       = 1'b0;
    IsBranchQ101H  = 1'b0;
    AluOpQ101H     = coreDpPkg::ADD;
    ImmediateQ101H = {{20{InstQ101H[31]}}, InstQ101H[31:20]}; // I-type
    case (OpcodeQ101H)
      coreDpPkg::OP: begin
        RegWrEnQ101H = 1'b1;
        AluOpQ101H   = aluOpOf(InstQ101H[14:12], InstQ101H[30], 1'b1);
      end
      coreDpPkg::OP_IMM: begin
        RegWrEnQ101H   = 1'b1;
        SelAluImmQ101H = 1'b1;
        AluOpQ101H     = aluOpOf(InstQ101H[14:12], InstQ101H[30], 1'b0);
      end
      coreDpPkg::LUI: begin
        RegWrEnQ101H   = 1'b1;
        SelAluImmQ101H = 1'b1;
        LuiQ101H       = 1'b1;                   // Imm straight through
        ImmediateQ101H = {InstQ101H[31:12], 12'b0}; // U-type
      end
      coreDpPkg::AUIPC: begin
        RegWrEnQ101H   = 1'b1;
        SelAluPcQ101H  = 1'b1; // PC + U-imm
        SelAluImmQ101H = 1'b1;
        ImmediateQ101H = {InstQ101H[31:12], 12'b0};
      end
      coreDpPkg::BRANCH: begin
        IsBranchQ101H  = 1'b1;
        SelAluPcQ101H  = 1'b1; // ALU forms the target
        SelAluImmQ101H = 1'b1;
        ImmediateQ101H = {{19{InstQ101H[31]}}, InstQ101H[31], InstQ101H[7],
                          InstQ101H[30:25], InstQ101H[11:8], 1'b0}; // B-type
      end
      default: ; // Anything else is a no-op
    endcase
  end

  // ==================================================
  // Q101H to Q102H flops
  // ==================================================
  always_ff @(posedge Clock or negedge arstN) begin : flagsQ102H
    if (!arstN) begin
      ValidQ102H    <= 1'b0;
      RegWrEnQ102H  <= 1'b0;
      IsBranchQ102H <= 1'b0;
    end else if (ReadyQ103H) begin
      ValidQ102H    <= InstValidQ101H;
      RegWrEnQ102H  <= InstValidQ101H && RegWrEnQ101H;  // Bubble never writes
      IsBranchQ102H <= InstValidQ101H && IsBranchQ101H;
    end
  end

  always_ff @(posedge Clock) begin : fieldsQ102H
    if (ReadyQ103H) begin
      RegSrc1Q102H       <= RegSrc1Q101H;
      RegSrc2Q102H       <= RegSrc2Q101H;
      RegDstQ102H        <= InstQ101H[11:7];
      SelAluPcQ102H      <= SelAluPcQ101H;
      SelAluImmQ102H     <= SelAluImmQ101H;
      LuiQ102H           <= LuiQ101H;
      AluOpQ102H         <= AluOpQ101H;
      BranchOpQ102H      <= coreDpPkg::tBranchOp'(InstQ101H[14:12]);
      ImmediateQ102H     <= ImmediateQ101H;
      PcQ102H            <= PcQ101H;
      PreRegRdData1Q102H <= RegRdData1Q101H; // Forwarding fixes these up in exe
      PreRegRdData2Q102H <= RegRdData2Q101H;
    end
  end

endmodule

// ==== coreDpPkg.sv ====
package coreDpPkg;

  // ==================================================
  // Major opcodes, inst[6:0]
  // ==================================================
  typedef enum logic [6:0] {
    OP     = 7'b0110011, // Reg-reg arithmetic
    OP_IMM = 7'b0010011, // Reg-imm arithmetic
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    BRANCH = 7'b1100011  // Conditional branches
  } tOpcode;

  // ==================================================
  // ALU operations
  // ==================================================
  typedef enum logic [3:0] {
    ADD  = 4'd0, // Also AUIPC and branch target
    SUB  = 4'd1,
    SLT  = 4'd2,
    SLTU = 4'd3,
    SLL  = 4'd4, // Shifts use in2[4:0]
    SRL  = 4'd5,
    SRA  = 4'd6,
    XOR  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } tAluOp;

  // Branch compare, funct3 values as encoded
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } tBranchOp;

endpackage

// ==== coreDpTb.sv ====
`timescale 1ns/10ps
`include "coreDp_settings.svh"

module coreDpTb;

  logic                    Clock, arstN;
  logic                    InstValidQ101H, ReadyQ103H;
  logic [`COREDP_XLEN-1:0] InstQ101H, PcQ101H;
  logic                    RegWrEnQ105H, BranchValidQ103H, BranchTakenQ103H;
  logic [`COREDP_RIDX-1:0] RegDstQ105H;
  logic [`COREDP_XLEN-1:0] RegWrDataQ105H, BranchTargetQ103H;

  int                      seed;
  int                      issued;
  logic [`COREDP_XLEN-1:0] pc;
  logic [`COREDP_XLEN-1:0] modelRegs [`COREDP_NREGS]; // Architectural state, program order
  logic [`COREDP_RIDX-1:0] retDstQ [$];               // Expected retire triples
  logic [`COREDP_XLEN-1:0] retDataQ [$];
  logic                    brTakenQ [$];              // Expected branch reports
  logic [`COREDP_XLEN-1:0] brTargetQ [$];

  tbClock clockGen (.Clock, .arstN);

  coreDpTop dut (
    .Clock, .arstN, .InstValidQ101H, .InstQ101H, .PcQ101H, .ReadyQ103H,
    .RegWrEnQ105H, .RegDstQ105H, .RegWrDataQ105H,
    .BranchValidQ103H, .BranchTakenQ103H, .BranchTargetQ103H
  );

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Stopped at the first error");
  endtask

  function automatic int assertFailures();
    return dut.uExe.uExeChecks.ErrorCount + dut.uResult.uResultChecks.ErrorCount;
  endfunction

  // ==================================================
  // Random instruction from the kept set
  // ==================================================
  function automatic logic [31:0] randomInst();
    logic [31:0] r, imm;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  hi;
    r   = $random(seed);
    imm = $random(seed);
    rd  = {2'b0, r[2:0]}; // x0..x7, lots of hazards
    rs1 = {2'b0, r[5:3]};
    rs2 = {2'b0, r[8:6]};
    f3  = r[11:9];
    case (r[15:12] % 5)
      0: begin
        hi = (r[16] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0; // SUB, SRA
        randomInst = {hi, rs2, rs1, f3, rd, coreDpPkg::OP};
      end
      1: begin
        hi = (f3 == 3'b001) ? 7'b0 : (f3 == 3'b101) ? {1'b0, r[16], 5'b0} : imm[31:25];
        randomInst = {hi, imm[24:20], rs1, f3, rd, coreDpPkg::OP_IMM};
      end
      2: randomInst = {imm[31:12], rd, coreDpPkg::LUI};
      3: randomInst = {imm[31:12], rd, coreDpPkg::AUIPC};
      default: begin
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1; // funct3 2 and 3 are reserved
        end
        randomInst = {imm[31:25], rs2, rs1, f3, imm[11:7], coreDpPkg::BRANCH};
      end
    endcase
  endfunction

  // RV32I rules on the model's registers
  task automatic modelInst(input logic [31:0] inst, input logic [31:0] instPc);
    logic [31:0] a, b, res, immB;
    logic [4:0]  sh;
    logic        taken;
    a    = modelRegs[inst[19:15]];
    b    = modelRegs[inst[24:20]];
    immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    res  = '0;
    case (inst[6:0])
      coreDpPkg::OP, coreDpPkg::OP_IMM: begin
        if (inst[6:0] == coreDpPkg::OP_IMM) begin
          b = {{20{inst[31]}}, inst[31:20]};
        end
        sh = b[4:0];
        case (inst[14:12])
          3'b000: res = (inst[30] && inst[5]) ? a - b : a + b; // inst[5] set only on OP
          3'b001: res = a << sh;
          3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b011: res = (a < b) ? 32'd1 : 32'd0;
          3'b100: res = a ^ b;
          3'b101: begin
            if (inst[30]) begin
              res = $signed(a) >>> sh;
            end else begin
              res = a >> sh;
            end
          end
          3'b110: res = a | b;
          default: res = a & b;
        endcase
      end
      coreDpPkg::LUI:   res = {inst[31:12], 12'b0};
      coreDpPkg::AUIPC: res = instPc + {inst[31:12], 12'b0};
      default: begin
        case (inst[14:12])
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        brTakenQ.push_back(taken);
        brTargetQ.push_back(instPc + immB);
      end
    endcase
    if (inst[6:0] != coreDpPkg::BRANCH) begin
      retDstQ.push_back(inst[11:7]);
      retDataQ.push_back(res);
      if (inst[11:7] != 5'd0) begin
        modelRegs[inst[11:7]] = res; // x0 stays zero
      end
    end
  endtask

  // Outputs are stable at the falling edge; Ready is the value for the next rise
  task automatic checkOutputs();
    assert (assertFailures() == 0) else failRun("A bound concurrent assertion fired");
    if (ReadyQ103H && RegWrEnQ105H === 1'b1) begin
      assert (retDstQ.size() != 0) else failRun("Retire port fired with nothing in flight");
      assert (RegDstQ105H === retDstQ[0] && RegWrDataQ105H === retDataQ[0]) else
        failRun($sformatf("Error at %0t: retired x%0d = %h, expected x%0d = %h", $time,
                          RegDstQ105H, RegWrDataQ105H, retDstQ[0], retDataQ[0]));
      void'(retDstQ.pop_front());
      void'(retDataQ.pop_front());
    end
    if (ReadyQ103H && BranchValidQ103H === 1'b1) begin
      assert (brTakenQ.size() != 0) else failRun("Branch report with no branch in flight");
      assert (BranchTakenQ103H === brTakenQ[0] && BranchTargetQ103H === brTargetQ[0]) else
        failRun($sformatf("Error at %0t: branch taken %b target %h, expected %b %h", $time,
                          BranchTakenQ103H, BranchTargetQ103H, brTakenQ[0], brTargetQ[0]));
      void'(brTakenQ.pop_front());
      void'(brTargetQ.pop_front());
    end
  endtask

  task automatic stepCycle(input bit canIssue, input bit canStall);
    logic [31:0] inst;
    @(negedge Clock);
    ReadyQ103H = !canStall || (($random(seed) & 3) != 0); // About one stall in four
    checkOutputs();
    InstValidQ101H = 1'b0;
    if (ReadyQ103H && canIssue && (($random(seed) & 15) != 0)) begin
      inst           = randomInst();
      InstValidQ101H = 1'b1;
      InstQ101H      = inst;
      PcQ101H        = pc;
      modelInst(inst, pc);
      pc     = pc + 32'd4;
      issued = issued + 1;
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin : stimulus
    int waitCycles;
    seed           = 32'h6ebe_f0b6;
    InstValidQ101H = 1'b0;
    InstQ101H      = '0; // Opcode 0 is a no-op
    PcQ101H        = '0;
    ReadyQ103H     = 1'b1;
    pc             = 32'h0000_1000;
    issued         = 0;
    for (int i = 0; i < `COREDP_NREGS; i++) begin
      modelRegs[i] = '0;
    end
    waitCycles = 0;
    while (arstN !== 1'b1) begin
      @(negedge Clock);
      waitCycles++;
      if (waitCycles > 20) failRun("Reset was never released");
    end
    for (int i = 0; i < 8; i++) begin
      stepCycle(1'b0, 1'b0); // Idle pipe, nothing may retire
    end
    waitCycles = 0;
    while (issued < 400) begin
      stepCycle(1'b1, 1'b1);
      waitCycles++;
      if (waitCycles > 4000) failRun("Issue phase never finished, too many stalls");
    end
    waitCycles = 0;
    while (retDstQ.size() != 0 || brTakenQ.size() != 0) begin
      stepCycle(1'b0, 1'b1);
      waitCycles++;
      if (waitCycles > 100) failRun("Timeout: retirement never arrived for instructions in flight");
    end
    for (int i = 0; i < 4; i++) begin
      stepCycle(1'b0, 1'b0); // Tail, catches late spurious retires
    end
    if (assertFailures() != 0) begin
      failRun("A bound concurrent assertion fired");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// ==== coreDpTop.sv ====
`timescale 1ns/10ps
`include "coreDp_settings.svh"

module coreDpTop (
  input  logic                    Clock,
  input  logic                    arstN,
  input  logic                    InstValidQ101H,
  input  logic [`COREDP_XLEN-1:0] InstQ101H,
  input  logic [`COREDP_XLEN-1:0] PcQ101H,
  input  logic                    ReadyQ103H,
  output logic                    RegWrEnQ105H,
  output logic [`COREDP_RIDX-1:0] RegDstQ105H,
  output logic [`COREDP_XLEN-1:0] RegWrDataQ105H,
  output logic                    BranchValidQ103H,
  output logic                    BranchTakenQ103H,
  output logic [`COREDP_XLEN-1:0] BranchTargetQ103H
);

  // Q101H
  logic [`COREDP_RIDX-1:0] RegSrc1Q101H, RegSrc2Q101H;
  logic [`COREDP_XLEN-1:0] RegRdData1Q101H, RegRdData2Q101H;
  // Q102H control set
  logic                    ValidQ102H, RegWrEnQ102H, IsBranchQ102H;
  logic                    SelAluPcQ102H, SelAluImmQ102H, LuiQ102H, BranchCondMetQ102H;
  logic [`COREDP_RIDX-1:0] RegSrc1Q102H, RegSrc2Q102H, RegDstQ102H;
  coreDpPkg::tAluOp        AluOpQ102H;
  coreDpPkg::tBranchOp     BranchOpQ102H;
  logic [`COREDP_XLEN-1:0] ImmediateQ102H, PcQ102H, PreRegRdData1Q102H, PreRegRdData2Q102H;
  // Q103H..Q104H forwarding fields
  logic [`COREDP_RIDX-1:0] RegDstQ103H, RegDstQ104H;
  logic                    RegWrEnQ103H, RegWrEnQ104H;
  logic [`COREDP_XLEN-1:0] AluOutQ103H, AluOutQ104H;

  coreDecode uDecode (
    .Clock, .arstN, .ReadyQ103H, .InstValidQ101H, .InstQ101H, .PcQ101H,
    .RegRdData1Q101H, .RegRdData2Q101H, .RegSrc1Q101H, .RegSrc2Q101H,
    .ValidQ102H, .RegSrc1Q102H, .RegSrc2Q102H, .RegDstQ102H, .RegWrEnQ102H,
    .SelAluPcQ102H, .SelAluImmQ102H, .LuiQ102H, .AluOpQ102H, .IsBranchQ102H,
    .BranchOpQ102H, .ImmediateQ102H, .PcQ102H, .PreRegRdData1Q102H, .PreRegRdData2Q102H
  );

  coreRegFile uRegFile (
    .Clock, .arstN, .RegSrc1Q101H, .RegSrc2Q101H,
    .WrEn (RegWrEnQ105H && ReadyQ103H), // No writeback while stalled
    .RegDstQ105H, .RegWrDataQ105H, .RegRdData1Q101H, .RegRdData2Q101H
  );

  coreExe uExe (
    .Clock, .arstN, .ReadyQ103H, .RegSrc1Q102H, .RegSrc2Q102H, .SelAluPcQ102H,
    .SelAluImmQ102H, .LuiQ102H, .AluOpQ102H, .BranchOpQ102H, .ImmediateQ102H, .PcQ102H,
    .PreRegRdData1Q102H, .PreRegRdData2Q102H, .RegDstQ103H, .RegDstQ104H, .RegDstQ105H,
    .RegWrEnQ103H, .RegWrEnQ104H, .RegWrEnQ105H, .AluOutQ104H, .RegWrDataQ105H,
    .BranchCondMetQ102H, .AluOutQ103H
  );

  coreResult uResult (
    .Clock, .arstN, .ReadyQ103H, .ValidQ102H, .RegDstQ102H, .RegWrEnQ102H,
    .IsBranchQ102H, .BranchCondMetQ102H, .AluOutQ103H, .RegDstQ103H, .RegDstQ104H,
    .RegDstQ105H, .RegWrEnQ103H, .RegWrEnQ104H, .RegWrEnQ105H, .AluOutQ104H,
    .RegWrDataQ105H, .BranchValidQ103H, .BranchTakenQ103H, .BranchTargetQ103H
  );

endmodule

// ==== coreDp_assertions.sv ====
`timescale 1ns/10ps
`include "coreDp_settings.svh"

module coreDpAssertions #(
  parameter int HeldWidth = 1,   // Width of the state frozen by a stall
  parameter bit ExeSide   = 1'b0 // Forwarding checks on the execute instance
) (
  input logic                    Clock,
  input logic                    arstN,
  input logic                    ReadyQ103H,
  input logic [`COREDP_RIDX-1:0] RegSrc1Q102H,
  input logic [`COREDP_RIDX-1:0] RegSrc2Q102H,
  input logic [`COREDP_XLEN-1:0] Operand1Q102H, // Forwarded rs1
  input logic [`COREDP_XLEN-1:0] Operand2Q102H, // Forwarded rs2
  input logic [`COREDP_RIDX-1:0] RegDstQ103H,
  input logic [`COREDP_RIDX-1:0] RegDstQ104H,
  input logic                    RegWrEnQ103H,
  input logic                    RegWrEnQ104H,
  input logic                    RegWrEnQ105H,
  input logic [`COREDP_XLEN-1:0] AluOutQ103H,
  input logic                    BranchValidQ103H,
  input logic                    BranchTakenQ103H,
  input logic [HeldWidth-1:0]    HeldState
);

  int ErrorCount = 0; // Read by the testbench

  if (ExeSide) begin : fwdChecks
    // ==================================================
    // Forwarding
    // ==================================================
    zeroSrc1: assert property (@(posedge Clock) disable iff (!arstN)
        (RegSrc1Q102H == '0) |-> (Operand1Q102H == '0))
      else begin
        $error("x0 read as nonzero on rs1");
        ErrorCount++;
      end
    zeroSrc2: assert property (@(posedge Clock) disable iff (!arstN)
        (RegSrc2Q102H == '0) |-> (Operand2Q102H == '0))
      else begin
        $error("x0 read as nonzero on rs2");
        ErrorCount++;
      end

    // Q103H and Q104H both hit, Q103H must win
    newestSrc1: assert property (@(posedge Clock) disable iff (!arstN)
        (RegWrEnQ103H && RegWrEnQ104H && (RegSrc1Q102H != '0) &&
         (RegSrc1Q102H == RegDstQ103H) && (RegSrc1Q102H == RegDstQ104H))
        |-> (Operand1Q102H == AluOutQ103H))
      else begin
        $error("rs1 forwarded from an older producer");
        ErrorCount++;
      end
    newestSrc2: assert property (@(posedge Clock) disable iff (!arstN)
        (RegWrEnQ103H && RegWrEnQ104H && (RegSrc2Q102H != '0) &&
         (RegSrc2Q102H == RegDstQ103H) && (RegSrc2Q102H == RegDstQ104H))
        |-> (Operand2Q102H == AluOutQ103H))
      else begin
        $error("rs2 forwarded from an older producer");
        ErrorCount++;
      end
  end else begin : reportChecks
    // Retire and branch report low once a reset edge has passed
    resetQuiet: assert property (@(posedge Clock)
        !arstN |=> (!RegWrEnQ105H && !BranchValidQ103H && !BranchTakenQ103H))
      else begin
        $error("Retire or branch report active in reset");
        ErrorCount++;
      end
  end

  // ==================================================
  // Stall behavior
  // ==================================================
  stallHold: assert property (@(posedge Clock) disable iff (!arstN)
      !ReadyQ103H |=> $stable(HeldState))
    else begin
      $error("Pipeline state moved during a stall");
      ErrorCount++;
    end

endmodule

// Exe side checks forwarding, branch ports unused there
bind coreExe coreDpAssertions #(.HeldWidth(`COREDP_XLEN), .ExeSide(1'b1)) uExeChecks (
  .Clock, .arstN, .ReadyQ103H, .RegSrc1Q102H, .RegSrc2Q102H,
  .Operand1Q102H (RegRdData1Q102H),
  .Operand2Q102H (RegRdData2Q102H),
  .RegDstQ103H, .RegDstQ104H, .RegWrEnQ103H, .RegWrEnQ104H, .RegWrEnQ105H, .AluOutQ103H,
  .BranchValidQ103H (1'b0),
  .BranchTakenQ103H (1'b0),
  .HeldState (AluOutQ103H)
);

// Result side watches Q103H..Q105H and the branch report
bind coreResult coreDpAssertions #(.HeldWidth(3 * `COREDP_RIDX + 2 * `COREDP_XLEN + 5))
  uResultChecks (
  .Clock, .arstN, .ReadyQ103H,
  .RegSrc1Q102H ('0),
  .RegSrc2Q102H ('0),
  .Operand1Q102H ('0),
  .Operand2Q102H ('0),
  .RegDstQ103H, .RegDstQ104H, .RegWrEnQ103H, .RegWrEnQ104H, .RegWrEnQ105H, .AluOutQ103H,
  .BranchValidQ103H, .BranchTakenQ103H,
  .HeldState ({RegDstQ103H, RegDstQ104H, RegDstQ105H, RegWrEnQ103H, RegWrEnQ104H,
               RegWrEnQ105H, AluOutQ104H, RegWrDataQ105H, BranchValidQ103H,
               BranchTakenQ103H})
);

// ==== coreDp_settings.svh ====
`ifndef COREDP_SETTINGS_SVH
`define COREDP_SETTINGS_SVH

// ==================================================
// Datapath sizing
// ==================================================
`define COREDP_XLEN  32 // Data and PC width
`define COREDP_NREGS 32 // Architectural registers, x0 included
`define COREDP_RIDX  5  // Register index width

`endif

// ==== coreExe.sv ====
`timescale 1ns/10ps
`include "coreDp_settings.svh"

module coreExe (
  input  logic                    Clock,
  input  logic                    arstN,
  input  logic                    ReadyQ103H,
  input  logic [`COREDP_RIDX-1:0] RegSrc1Q102H,
  input  logic [`COREDP_RIDX-1:0] RegSrc2Q102H,
  input  logic                    SelAluPcQ102H,
  input  logic                    SelAluImmQ102H,
  input  logic                    LuiQ102H,
  input  coreDpPkg::tAluOp        AluOpQ102H,
  input  coreDpPkg::tBranchOp     BranchOpQ102H,
  input  logic [`COREDP_XLEN-1:0] ImmediateQ102H,
  input  logic [`COREDP_XLEN-1:0] PcQ102H,
  input  logic [`COREDP_XLEN-1:0] PreRegRdData1Q102H,
  input  logic [`COREDP_XLEN-1:0] PreRegRdData2Q102H,
  input  logic [`COREDP_RIDX-1:0] RegDstQ103H,
  input  logic [`COREDP_RIDX-1:0] RegDstQ104H,
  input  logic [`COREDP_RIDX-1:0] RegDstQ105H,
  input  logic                    RegWrEnQ103H,
  input  logic                    RegWrEnQ104H,
  input  logic                    RegWrEnQ105H,
  input  logic [`COREDP_XLEN-1:0] AluOutQ104H,    // Forward source
  input  logic [`COREDP_XLEN-1:0] RegWrDataQ105H, // Forward source
  output logic                    BranchCondMetQ102H,
  output logic [`COREDP_XLEN-1:0] AluOutQ103H
);

  logic Hazard1Data1Q102H, Hazard2Data1Q102H, Hazard3Data1Q102H;
  logic Hazard1Data2Q102H, Hazard2Data2Q102H, Hazard3Data2Q102H;
  logic [`COREDP_XLEN-1:0] RegRdData1Q102H, RegRdData2Q102H;
  logic [`COREDP_XLEN-1:0] AluIn1Q102H, AluIn2Q102H, AluOutQ102H;
  logic [4:0]              ShamtQ102H;

  // ==================================================
  // RAW hazards vs Q103H..Q105H, x0 never forwarded
  // ==================================================
  assign Hazard1Data1Q102H = RegWrEnQ103H && (RegSrc1Q102H == RegDstQ103H) && (RegSrc1Q102H != '0);
  assign Hazard2Data1Q102H = RegWrEnQ104H && (RegSrc1Q102H == RegDstQ104H) && (RegSrc1Q102H != '0);
  assign Hazard3Data1Q102H = RegWrEnQ105H && (RegSrc1Q102H == RegDstQ105H) && (RegSrc1Q102H != '0);
  assign Hazard1Data2Q102H = RegWrEnQ103H && (RegSrc2Q102H == RegDstQ103H) && (RegSrc2Q102H != '0);
  assign Hazard2Data2Q102H = RegWrEnQ104H && (RegSrc2Q102H == RegDstQ104H) && (RegSrc2Q102H != '0);
  assign Hazard3Data2Q102H = RegWrEnQ105H && (RegSrc2Q102H == RegDstQ105H) && (RegSrc2Q102H != '0);

  // Newest producer wins
  assign RegRdData1Q102H = Hazard1Data1Q102H ? AluOutQ103H    :
                           Hazard2Data1Q102H ? AluOutQ104H    :
                           Hazard3Data1Q102H ? RegWrDataQ105H :
                                               PreRegRdData1Q102H; // No hazard
  assign RegRdData2Q102H = Hazard1Data2Q102H ? AluOutQ103H    :
                           Hazard2Data2Q102H ? AluOutQ104H    :
                           Hazard3Data2Q102H ? RegWrDataQ105H :
                                               PreRegRdData2Q102H;

  // ==================================================
  // ALU
  // ==================================================
  assign AluIn1Q102H = SelAluPcQ102H  ? PcQ102H        : RegRdData1Q102H; // AUIPC, branch
  assign AluIn2Q102H = SelAluImmQ102H ? ImmediateQ102H : RegRdData2Q102H;
  assign ShamtQ102H  = AluIn2Q102H[4:0];

  always_comb begin : aluLogic
    case (AluOpQ102H)
      coreDpPkg::SUB:  AluOutQ102H = AluIn1Q102H - AluIn2Q102H;
      coreDpPkg::SLT:  AluOutQ102H = {31'b0, $signed(AluIn1Q102H) < $signed(AluIn2Q102H)};
      coreDpPkg::SLTU: AluOutQ102H = {31'b0, AluIn1Q102H < AluIn2Q102H};
      coreDpPkg::SLL:  AluOutQ102H = AluIn1Q102H << ShamtQ102H;
      coreDpPkg::SRL:  AluOutQ102H = AluIn1Q102H >> ShamtQ102H;
      coreDpPkg::SRA:  AluOutQ102H = $signed(AluIn1Q102H) >>> ShamtQ102H; // Sign fill
      coreDpPkg::XOR:  AluOutQ102H = AluIn1Q102H ^ AluIn2Q102H;
      coreDpPkg::OR:   AluOutQ102H = AluIn1Q102H | AluIn2Q102H;
      coreDpPkg::AND:  AluOutQ102H = AluIn1Q102H & AluIn2Q102H;
      default:         AluOutQ102H = AluIn1Q102H + AluIn2Q102H; // ADD
    endcase
    if (LuiQ102H) AluOutQ102H = AluIn2Q102H; // LUI just passes imm
  end

  // Branch compare on forwarded operands
  always_comb begin : branchComp
    case (BranchOpQ102H)
      coreDpPkg::BEQ:  BranchCondMetQ102H = (RegRdData1Q102H == RegRdData2Q102H);
      coreDpPkg::BNE:  BranchCondMetQ102H = (RegRdData1Q102H != RegRdData2Q102H);
      coreDpPkg::BLT:  BranchCondMetQ102H = $signed(RegRdData1Q102H) < $signed(RegRdData2Q102H);
      coreDpPkg::BGE:  BranchCondMetQ102H = $signed(RegRdData1Q102H) >= $signed(RegRdData2Q102H);
      coreDpPkg::BLTU: BranchCondMetQ102H = RegRdData1Q102H < RegRdData2Q102H;
      coreDpPkg::BGEU: BranchCondMetQ102H = RegRdData1Q102H >= RegRdData2Q102H;
      default:         BranchCondMetQ102H = 1'b0; // Reserved funct3
    endcase
  end

  // Q102H to Q103H
  always_ff @(posedge Clock or negedge arstN) begin : aluOutQ103H
    if (!arstN) begin
      AluOutQ103H <= '0;
    end else if (ReadyQ103H) begin
      AluOutQ103H <= AluOutQ102H;
    end
  end

endmodule

// ==== coreRegFile.sv ====
`timescale 1ns/10ps
`include "coreDp_settings.svh"

module coreRegFile (
  input  logic                    Clock,
  input  logic                    arstN,
  input  logic [`COREDP_RIDX-1:0] RegSrc1Q101H,
  input  logic [`COREDP_RIDX-1:0] RegSrc2Q101H,
  input  logic                    WrEn,
  input  logic [`COREDP_RIDX-1:0] RegDstQ105H,
  input  logic [`COREDP_XLEN-1:0] RegWrDataQ105H,
  output logic [`COREDP_XLEN-1:0] RegRdData1Q101H,
  output logic [`COREDP_XLEN-1:0] RegRdData2Q101H
);

  logic [`COREDP_XLEN-1:0] Regs [`COREDP_NREGS-1:1]; // x0 has no storage

  always_ff @(posedge Clock or negedge arstN) begin : regWrite
    if (!arstN) begin
      for (int i = 1; i < `COREDP_NREGS; i++) begin
        Regs[i] <= '0;
      end
    end else if (WrEn && (RegDstQ105H != '0)) begin
      Regs[RegDstQ105H] <= RegWrDataQ105H;
    end
  end

  // Read ports, x0 first, then write-first bypass
  assign RegRdData1Q101H = (RegSrc1Q101H == '0)                   ? '0             :
                           (WrEn && (RegDstQ105H == RegSrc1Q101H)) ? RegWrDataQ105H :
                                                                     Regs[RegSrc1Q101H];
  assign RegRdData2Q101H = (RegSrc2Q101H == '0)                   ? '0             :
                           (WrEn && (RegDstQ105H == RegSrc2Q101H)) ? RegWrDataQ105H :
                                                                     Regs[RegSrc2Q101H];

endmodule

// ==== coreResult.sv ====
`timescale 1ns/10ps
`include "coreDp_settings.svh"

module coreResult (
  input  logic                    Clock,
  input  logic                    arstN,
  input  logic                    ReadyQ103H,
  input  logic                    ValidQ102H,
  input  logic [`COREDP_RIDX-1:0] RegDstQ102H,
  input  logic                    RegWrEnQ102H,
  input  logic                    IsBranchQ102H,
  input  logic                    BranchCondMetQ102H,
  input  logic [`COREDP_XLEN-1:0] AluOutQ103H,
  output logic [`COREDP_RIDX-1:0] RegDstQ103H,
  output logic [`COREDP_RIDX-1:0] RegDstQ104H,
  output logic [`COREDP_RIDX-1:0] RegDstQ105H,
  output logic                    RegWrEnQ103H,
  output logic                    RegWrEnQ104H,
  output logic                    RegWrEnQ105H,
  output logic [`COREDP_XLEN-1:0] AluOutQ104H,
  output logic [`COREDP_XLEN-1:0] RegWrDataQ105H,
  output logic                    BranchValidQ103H,
  output logic                    BranchTakenQ103H,
  output logic [`COREDP_XLEN-1:0] BranchTargetQ103H
);

  logic BranchCondMetQ103H;

  // ==================================================
  // Control down the pipe, frozen while stalled
  // ==================================================
  always_ff @(posedge Clock or negedge arstN) begin : ctrlPipe
    if (!arstN) begin
      RegWrEnQ103H       <= 1'b0;
      RegWrEnQ104H       <= 1'b0;
      RegWrEnQ105H       <= 1'b0;
      BranchValidQ103H   <= 1'b0;
      BranchCondMetQ103H <= 1'b0;
    end else if (ReadyQ103H) begin
      RegWrEnQ103H       <= ValidQ102H && RegWrEnQ102H;
      RegWrEnQ104H       <= RegWrEnQ103H;
      RegWrEnQ105H       <= RegWrEnQ104H;
      BranchValidQ103H   <= ValidQ102H && IsBranchQ102H;
      BranchCondMetQ103H <= BranchCondMetQ102H;
    end
  end

  // Destination and result
  always_ff @(posedge Clock) begin : dataPipe
    if (ReadyQ103H) begin
      RegDstQ103H    <= RegDstQ102H;
      RegDstQ104H    <= RegDstQ103H;
      RegDstQ105H    <= RegDstQ104H;
      AluOutQ104H    <= AluOutQ103H;
      RegWrDataQ105H <= AluOutQ104H; // Writeback value
    end
  end

  // Branch report from the Q103H flops
  assign BranchTakenQ103H  = BranchValidQ103H && BranchCondMetQ103H;
  assign BranchTargetQ103H = AluOutQ103H; // PC + B-imm from the ALU

endmodule

// ==== filelist.f ====
+incdir+.
coreDpPkg.sv
coreDecode.sv
coreRegFile.sv
coreExe.sv
coreResult.sv
coreDpTop.sv
tbClock.sv
coreDp_assertions.sv
coreDpTb.sv

// ==== tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
  output logic Clock,
  output logic arstN
);

  initial begin : clockGen
    Clock = 1'b0;
    forever #10 Clock = ~Clock; // 20 ns period
  end

  // Reset low over three rising edges, released mid-cycle
  initial begin : resetGen
    arstN = 1'b0;
    repeat (3) @(posedge Clock);
    @(negedge Clock);
    arstN = 1'b1;
  end

endmodule
